// File: logic/muldiv_pkg.sv
// muldiv_pkg: execute opcodes, HI/LO extend codes and the shared 64-bit result word
`default_nettype none

package muldiv_pkg;

  localparam int DATA_W = 32;  // operand width

  // execute-stage opcodes seen by the multiply/divide block
  typedef enum logic [4:0] {
    NOP   = 5'h00,
    MULT  = 5'h01,
    MULTU = 5'h02,
    MADD  = 5'h03,
    MADDU = 5'h04,
    MSUB  = 5'h05,
    MSUBU = 5'h06,
    DIV   = 5'h07,
    DIVU  = 5'h08  // any other code behaves as NOP
  } muldiv_op_e;

  // what HI/LO does with a finished result
  typedef enum logic [1:0] {
    WRITE = 2'b00,
    ADD   = 2'b01,
    SUB   = 2'b10
  } extend_op_e;

  // one 64-bit word, read as a product or as divider output
  typedef union packed {
    struct packed {
      logic [DATA_W-1:0] hi;
      logic [DATA_W-1:0] lo;
    } prod;
    struct packed {
      logic [DATA_W-1:0] quotient;
      logic [DATA_W-1:0] remainder;
    } qr;
  } hilo_word_u;

endpackage

`default_nettype wire

// File: logic/div_if.sv
// div_if: valid/ready link between the multiply/divide unit and the divider
`timescale 1ns/100ps
`default_nettype none

interface div_if;
  import muldiv_pkg::*;

  logic              in_valid;   // request, held until in_ready
  logic [DATA_W-1:0] dividend;
  logic [DATA_W-1:0] divisor;
  logic              is_signed;
  logic              in_ready;   // divider idle
  logic              out_valid;  // single-cycle result pulse
  hilo_word_u        result;

  modport master (
    output in_valid, dividend, divisor, is_signed,
    input  in_ready, out_valid, result
  );

  modport slave (
    input  in_valid, dividend, divisor, is_signed,
    output in_ready, out_valid, result
  );

endinterface

`default_nettype wire

// File: logic/booth_wallace_mul.sv
// booth_wallace_mul: radix-4 Booth multiplier with a Wallace-tree reduction, two cycles
`timescale 1ns/100ps
`default_nettype none

module booth_gen (
  input  logic [63:0] x,
  input  logic [2:0]  y,  // {y[2i+1], y[2i], y[2i-1]}
  output logic [63:0] p,
  output logic        c
);

  always_comb begin
    case (y)
      3'b001, 3'b010: p = x;
      3'b011:         p = x << 1;
      3'b100:         p = ~(x << 1);  // -2x, low one comes from c
      3'b101, 3'b110: p = ~x;         // -x
      default:        p = '0;         // 000 and 111
    endcase
  end

  assign c = y[2] & ~(y[1] & y[0]);  // +1 for the inverted multiples

endmodule

module wallace_unit_17 (
  input  logic [16:0] in,
  input  logic [14:0] cin,
  output logic        c,
  output logic        out,
  output logic [14:0] cout
);

  logic [14:0] s;

  always_comb begin
    // first level over the partial-product bits
    for (int k = 0; k < 5; k++) begin
      {cout[k], s[k]} = in[3*k] + in[3*k+1] + in[3*k+2];
    end
    {cout[5], s[5]} = in[15] + in[16];  // the single half adder

    // second level, neighbour carries join here
    {cout[6], s[6]} = s[0] + s[1] + s[2];
    {cout[7], s[7]} = s[3] + s[4] + s[5];
    {cout[8], s[8]} = cin[0] + cin[1] + cin[2];
    {cout[9], s[9]} = cin[3] + cin[4] + cin[5];

    {cout[10], s[10]} = s[6] + s[7] + s[8];
    {cout[11], s[11]} = s[9] + cin[6] + cin[7];
    {cout[12], s[12]} = s[10] + s[11] + cin[8];
    {cout[13], s[13]} = cin[9] + cin[10] + cin[11];
    {cout[14], s[14]} = s[12] + s[13] + cin[12];
    {c, out}          = s[14] + cin[13] + cin[14];
  end

endmodule

module booth_wallace_mul (
  input  logic                          clk,
  input  logic                          is_signed,
  input  logic [muldiv_pkg::DATA_W-1:0] x,
  input  logic [muldiv_pkg::DATA_W-1:0] y,
  output muldiv_pkg::hilo_word_u        product
);
  import muldiv_pkg::*;

  localparam int N_PP = DATA_W / 2 + 1;  // 17 Booth rows
  localparam int P_W  = 2 * DATA_W;

  logic [P_W-1:0]    x_ext;
  logic [DATA_W+2:0] y_ext;
  wire  [P_W-1:0]    pp [N_PP];
  wire  [N_PP-1:0]   pp_neg;
  logic [N_PP-1:0]   col [P_W];      // partial products by column
  logic [N_PP-1:0]   col_q [P_W];
  logic [N_PP-1:0]   neg_q;
  wire  [14:0]       carry_chain [P_W+1];
  wire  [P_W-1:0]    col_carry;
  wire  [P_W-1:0]    col_sum;

  assign x_ext = {{DATA_W{is_signed & x[DATA_W-1]}}, x};
  assign y_ext = {{2{is_signed & y[DATA_W-1]}}, y, 1'b0};

  for (genvar i = 0; i < N_PP; i++) begin : g_row
    booth_gen u_gen (
      .x (x_ext << (2 * i)),
      .y (y_ext[2*i +: 3]),
      .p (pp[i]),
      .c (pp_neg[i])
    );
  end

  // transpose rows into columns
  always_comb begin
    for (int j = 0; j < P_W; j++) begin
      for (int i = 0; i < N_PP; i++) begin
        col[j][i] = pp[i][j];
      end
    end
  end

  always_ff @(posedge clk) begin
    col_q <= col;
    neg_q <= pp_neg;
  end

  // all row carries weigh 2^0, since the inverted rows cover the low bits too
  assign carry_chain[0] = neg_q[14:0];

  for (genvar j = 0; j < P_W; j++) begin : g_col
    wallace_unit_17 u_col (
      .in   (col_q[j]),
      .cin  (carry_chain[j]),
      .c    (col_carry[j]),
      .out  (col_sum[j]),
      .cout (carry_chain[j+1])
    );
  end

  // final carry-propagate add, top column carry drops out
  assign product = {col_carry[P_W-2:0], neg_q[15]} + col_sum + P_W'(neg_q[16]);

endmodule

`default_nettype wire

// File: logic/radix2_divider.sv
// radix2_divider: iterative restoring divider for signed and unsigned 32-bit operands
`timescale 1ns/100ps
`default_nettype none

module radix2_divider #(
  parameter int DIV_ITER = 32
) (
  input logic  clk,
  input logic  reset,
  input logic  abort,
  div_if.slave div
);
  import muldiv_pkg::*;

  localparam int STEP  = DATA_W / DIV_ITER;  // quotient bits per cycle
  localparam int CNT_W = (DIV_ITER > 1) ? $clog2(DIV_ITER) : 1;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_CALC = 2'd1;
  localparam logic [1:0] S_FIX  = 2'd2;

  logic [1:0]        state;
  logic [CNT_W-1:0]  cnt;
  logic [DATA_W-1:0] rem_q;
  logic [DATA_W-1:0] quo_q;   // dividend bits shift out, quotient bits in
  logic [DATA_W-1:0] dsr_q;
  logic              quo_neg;
  logic              rem_neg;
  logic [DATA_W-1:0] rem_nxt;
  logic [DATA_W-1:0] quo_nxt;
  logic              a_neg;
  logic              b_neg;
  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;
  logic              accept;
  hilo_word_u        res;

  assign accept = div.in_valid && div.in_ready;
  assign a_neg  = div.is_signed & div.dividend[DATA_W-1];
  assign b_neg  = div.is_signed & div.divisor[DATA_W-1];
  assign a_mag  = a_neg ? -div.dividend : div.dividend;
  assign b_mag  = b_neg ? -div.divisor : div.divisor;

  // STEP shift-and-subtract steps per cycle
  always_comb begin
    logic [DATA_W:0] trial;
    logic [DATA_W:0] diff;
    rem_nxt = rem_q;
    quo_nxt = quo_q;
    for (int k = 0; k < STEP; k++) begin
      trial   = {rem_nxt, quo_nxt[DATA_W-1]};
      diff    = trial - {1'b0, dsr_q};
      quo_nxt = {quo_nxt[DATA_W-2:0], ~diff[DATA_W]};
      rem_nxt = diff[DATA_W] ? trial[DATA_W-1:0] : diff[DATA_W-1:0];  // restore on borrow
    end
  end

  always_ff @(posedge clk) begin
    if (reset || abort) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            state <= S_CALC;
            cnt   <= '0;
          end
        end
        S_CALC: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(DIV_ITER - 1)) begin
            state <= S_FIX;
          end
        end
        default: state <= S_IDLE;  // S_FIX lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      quo_q   <= a_mag;
      rem_q   <= '0;
      dsr_q   <= b_mag;
      quo_neg <= (a_neg ^ b_neg) & (|div.divisor);  // x/0 stays all ones
      rem_neg <= a_neg;
    end else if (state == S_CALC) begin
      quo_q <= quo_nxt;
      rem_q <= rem_nxt;
    end
  end

  // sign fix, truncation toward zero
  always_comb begin
    res.qr.quotient  = quo_neg ? -quo_q : quo_q;
    res.qr.remainder = rem_neg ? -rem_q : rem_q;  // follows the dividend
  end

  assign div.in_ready  = (state == S_IDLE);
  assign div.out_valid = (state == S_FIX);
  assign div.result    = res;

  // requester keeps off while a division runs
  assert property (@(posedge clk) disable iff (reset)
    $rose(div.in_valid) |-> ((state == S_IDLE) || div.out_valid))
    else $error("divider: request raised while busy");

endmodule

`default_nettype wire

// File: logic/muldiv_unit.sv
// muldiv_unit: decodes multiply/divide opcodes, sequences both engines and stalls the pipe
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit #(
  parameter int DIV_ITER = 32
) (
  input  logic                          clk,
  input  logic                          reset,
  input  muldiv_pkg::muldiv_op_e        alu_op,
  input  logic [muldiv_pkg::DATA_W-1:0] operand_a,
  input  logic [muldiv_pkg::DATA_W-1:0] operand_b,
  input  logic                          exception,
  output muldiv_pkg::hilo_word_u        result,
  output muldiv_pkg::extend_op_e        extend_op,
  output logic                          finish,
  output logic                          stall
);
  import muldiv_pkg::*;

  localparam logic       M_IDLE = 1'b0;
  localparam logic       M_DONE = 1'b1;
  localparam logic [1:0] D_IDLE = 2'd0;
  localparam logic [1:0] D_SEND = 2'd1;
  localparam logic [1:0] D_WAIT = 2'd2;

  logic              is_mul;
  logic              is_div;
  logic              mul_signed;
  logic              mul_state;
  logic [1:0]        div_state;
  logic              mul_finish;
  logic              div_finish;
  logic [DATA_W-1:0] dvd_q;
  logic [DATA_W-1:0] dsr_q;
  logic              div_signed_q;
  hilo_word_u        product;

  div_if div_bus ();

  always_comb begin
    is_mul     = 1'b0;
    is_div     = 1'b0;
    mul_signed = 1'b0;
    extend_op  = WRITE;
    case (alu_op)
      MULT:  begin is_mul = 1'b1; mul_signed = 1'b1; end
      MULTU: is_mul = 1'b1;
      MADD:  begin is_mul = 1'b1; mul_signed = 1'b1; extend_op = ADD; end
      MADDU: begin is_mul = 1'b1; extend_op = ADD; end
      MSUB:  begin is_mul = 1'b1; mul_signed = 1'b1; extend_op = SUB; end
      MSUBU: begin is_mul = 1'b1; extend_op = SUB; end
      DIV, DIVU: is_div = 1'b1;
      default: ;  // NOP
    endcase
  end

  booth_wallace_mul u_mul (
    .clk       (clk),
    .is_signed (mul_signed),
    .x         (operand_a),
    .y         (operand_b),
    .product   (product)
  );

  radix2_divider #(.DIV_ITER(DIV_ITER)) u_div (
    .clk   (clk),
    .reset (reset),
    .abort (exception),
    .div   (div_bus)
  );

  // multiply: one cycle of partial products, then done
  always_ff @(posedge clk) begin
    if (reset || exception) begin
      mul_state <= M_IDLE;
    end else if (mul_state == M_IDLE) begin
      mul_state <= is_mul ? M_DONE : M_IDLE;
    end else begin
      mul_state <= M_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || exception) begin
      div_state <= D_IDLE;
    end else begin
      case (div_state)
        D_IDLE:  if (is_div) div_state <= D_SEND;
        D_SEND:  if (div_bus.in_ready) div_state <= D_WAIT;
        D_WAIT:  if (div_bus.out_valid) div_state <= D_IDLE;
        default: div_state <= D_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (div_state == D_IDLE && is_div) begin  // operand capture
      dvd_q        <= operand_a;
      dsr_q        <= operand_b;
      div_signed_q <= (alu_op == DIV);
    end
  end

  assign div_bus.in_valid  = (div_state == D_SEND);
  assign div_bus.dividend  = dvd_q;
  assign div_bus.divisor   = dsr_q;
  assign div_bus.is_signed = div_signed_q;

  assign mul_finish = (mul_state == M_DONE);
  assign div_finish = (div_state == D_WAIT) && div_bus.out_valid;
  assign finish     = (mul_finish | div_finish) & ~exception;  // flushed result is dropped
  assign stall      = (is_mul & ~mul_finish) | (is_div & ~div_finish);

  // divider output goes remainder to hi, quotient to lo
  always_comb begin
    if (mul_finish) begin
      result = product;
    end else begin
      result.prod.hi = div_bus.result.qr.remainder;
      result.prod.lo = div_bus.result.qr.quotient;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(mul_finish && div_finish))
    else $error("muldiv_unit: multiply and divide finished together");

endmodule

`default_nettype wire

// File: logic/hilo_accum.sv
// hilo_accum: HI/LO register pair with load, accumulate and subtract
`timescale 1ns/100ps
`default_nettype none

module hilo_accum (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          finish,
  input  muldiv_pkg::extend_op_e        extend_op,
  input  muldiv_pkg::hilo_word_u        result,
  output logic [muldiv_pkg::DATA_W-1:0] hi,
  output logic [muldiv_pkg::DATA_W-1:0] lo
);
  import muldiv_pkg::*;

  logic [2*DATA_W-1:0] acc;  // current {hi, lo}
  logic [2*DATA_W-1:0] incoming;

  assign acc      = {hi, lo};
  assign incoming = {result.prod.hi, result.prod.lo};

  always_ff @(posedge clk) begin
    if (reset) begin
      hi <= '0;
      lo <= '0;
    end else if (finish) begin
      case (extend_op)
        ADD:     {hi, lo} <= acc + incoming;  // madd, wraps mod 2^64
        SUB:     {hi, lo} <= acc - incoming;
        default: {hi, lo} <= incoming;        // plain write, also divides
      endcase
    end
  end

  // the unit only ever hands over one of the three codes
  assert property (@(posedge clk) disable iff (reset)
    finish |-> (extend_op inside {WRITE, ADD, SUB}))
    else $error("hilo_accum: undefined extend code on finish");

endmodule

`default_nettype wire

// File: logic/muldiv_top.sv
// muldiv_top: multiply/divide execute block with its HI/LO registers
`timescale 1ns/100ps
`default_nettype none

module muldiv_top #(
  parameter int DIV_ITER = 32  // divider cycles per operation
) (
  input  logic                          clk,
  input  logic                          reset,
  input  muldiv_pkg::muldiv_op_e        alu_op,
  input  logic [muldiv_pkg::DATA_W-1:0] operand_a,
  input  logic [muldiv_pkg::DATA_W-1:0] operand_b,
  input  logic                          exception,
  output logic                          stall,
  output logic [muldiv_pkg::DATA_W-1:0] hi,
  output logic [muldiv_pkg::DATA_W-1:0] lo
);
  import muldiv_pkg::*;

  hilo_word_u unit_result;
  extend_op_e unit_ext;
  logic       unit_finish;

  muldiv_unit #(.DIV_ITER(DIV_ITER)) u_unit (
    .clk       (clk),
    .reset     (reset),
    .alu_op    (alu_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .exception (exception),
    .result    (unit_result),
    .extend_op (unit_ext),
    .finish    (unit_finish),
    .stall     (stall)
  );

  hilo_accum u_hilo (
    .clk       (clk),
    .reset     (reset),
    .finish    (unit_finish),
    .extend_op (unit_ext),
    .result    (unit_result),
    .hi        (hi),
    .lo        (lo)
  );

endmodule

`default_nettype wire

// File: sim/muldiv_ref.svh
// muldiv reference model: expected {hi, lo} after each multiply or divide opcode
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// full 64-bit product, operands sign- or zero-extended first
function automatic logic [63:0] full_product(input logic [31:0] a, input logic [31:0] b,
                                             input logic sgn);
  logic [63:0] ax;
  logic [63:0] bx;
  ax = sgn ? {{32{a[31]}}, a} : {32'h0, a};
  bx = sgn ? {{32{b[31]}}, b} : {32'h0, b};
  return ax * bx;  // low 64 bits are exact either way
endfunction

// {remainder, quotient} as it lands in {hi, lo}
function automatic logic [63:0] quotient_remainder(input logic [31:0] a, input logic [31:0] b,
                                                   input logic sgn);
  longint na;
  longint nb;
  longint q;
  longint r;
  if (b == 32'h0) begin
    return {a, 32'hffff_ffff};  // x/0 keeps the dividend in hi
  end
  na = sgn ? longint'($signed(a)) : longint'(a);
  nb = sgn ? longint'($signed(b)) : longint'(b);
  q  = na / nb;  // truncates toward zero
  r  = na % nb;  // sign of the dividend
  return {r[31:0], q[31:0]};
endfunction

// new {hi, lo} for one opcode applied to the current value
function automatic logic [63:0] next_hilo(input muldiv_op_e op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [63:0] acc);
  case (op)
    MULT:    return full_product(a, b, 1'b1);
    MULTU:   return full_product(a, b, 1'b0);
    MADD:    return acc + full_product(a, b, 1'b1);
    MADDU:   return acc + full_product(a, b, 1'b0);
    MSUB:    return acc - full_product(a, b, 1'b1);
    MSUBU:   return acc - full_product(a, b, 1'b0);
    DIV:     return quotient_remainder(a, b, 1'b1);
    DIVU:    return quotient_remainder(a, b, 1'b0);
    default: return acc;  // nop leaves hi/lo alone
  endcase
endfunction

`endif

// File: sim/muldiv_tb.sv
// muldiv_tb drives the multiply/divide block and checks hi/lo against a reference model
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;
  import muldiv_pkg::*;

  `include "muldiv_ref.svh"

  localparam int TIMEOUT = 200;  // max cycles per wait

  logic        clk;
  logic        reset;
  muldiv_op_e  alu_op;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic        exception;
  logic        stall;
  logic [31:0] hi;
  logic [31:0] lo;

  integer      seed = 32'hb41;
  int          errors = 0;
  int          checks = 0;
  int          timeouts = 0;
  logic [63:0] model;          // expected {hi, lo}
  logic [63:0] expect_q [$];   // one entry per finished operation
  logic [31:0] corners [4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
  muldiv_op_e  acc_ops [4] = '{MADD, MADDU, MSUB, MSUBU};

  muldiv_top #(.DIV_ITER(32)) muldiv_top_i (
    .clk       (clk),
    .reset     (reset),
    .alu_op    (alu_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .exception (exception),
    .stall     (stall),
    .hi        (hi),
    .lo        (lo)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s expected %h got %h at %0t ns", name, expected, actual, $time);
    end
  endtask

  // present an opcode on this edge, wait for stall to drop, queue the expected hi/lo
  task automatic issue(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b,
                       output int cycles);
    int n;
    n = 0;
    alu_op    <= op;
    operand_a <= a;
    operand_b <= b;
    @(negedge clk);
    while (stall && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (stall) begin
      timeouts++;
      errors++;
      $display("Timeout: stall still high %0d cycles after opcode %s", n, op.name());
    end
    cycles = n;
    model  = next_hilo(op, a, b, model);
    @(posedge clk);  // hi/lo load here
    expect_q.push_back(model);
  endtask

  // hi/lo checked between edges once per finished operation
  always @(negedge clk) begin
    logic [63:0] exp_word;
    if (expect_q.size() > 0) begin
      exp_word = expect_q.pop_front();
      compare("hi", exp_word[63:32], hi);
      compare("lo", exp_word[31:0], lo);
    end
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    int          lat;
    int          n;

    reset     = 1'b1;
    alu_op    = NOP;
    operand_a = '0;
    operand_b = '0;
    exception = 1'b0;
    model     = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);  // idle after reset
    compare("stall", 32'h0, stall);
    compare("hi", 32'h0, hi);
    compare("lo", 32'h0, lo);
    @(posedge clk);

    foreach (corners[i]) begin
      foreach (corners[j]) begin
        issue(MULT, corners[i], corners[j], lat);
        compare("stall cycles", 32'd1, lat);
        issue(MULTU, corners[i], corners[j], lat);
        compare("stall cycles", 32'd1, lat);
      end
    end
    for (int k = 0; k < 20; k++) begin
      a = $random(seed);
      b = $random(seed);
      issue(k[0] ? MULT : MULTU, a, b, lat);
      compare("stall cycles", 32'd1, lat);
    end

    // accumulate chain on top of the last product
    for (int k = 0; k < 24; k++) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      issue(acc_ops[r[1:0]], a, b, lat);
    end

    for (int k = 0; k < 20; k++) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      b = b >> r[4:0];  // spread divisor sizes
      if (r[6]) b = -b;
      issue(r[5] ? DIV : DIVU, a, b, lat);
    end
    issue(DIV, 32'h8000_0000, 32'hffff_ffff, lat);   // overflow corner
    issue(DIVU, 32'h8000_0000, 32'hffff_ffff, lat);
    issue(DIV, 32'hdead_beef, 32'h0, lat);           // divide by zero
    issue(DIVU, 32'hdead_beef, 32'h0, lat);
    issue(DIV, 32'h1234_5678, 32'h0, lat);

    // flush a divide part way through
    alu_op    <= DIV;
    operand_a <= 32'h7654_3210;
    operand_b <= 32'h0000_0123;
    repeat (8) @(posedge clk);
    @(negedge clk);
    compare("stall", 32'h1, stall);
    @(posedge clk);
    exception <= 1'b1;  // opcode still held this cycle
    @(posedge clk);
    exception <= 1'b0;
    alu_op    <= NOP;
    @(negedge clk);
    compare("stall", 32'h0, stall);
    @(posedge clk);
    expect_q.push_back(model);  // hi/lo unchanged
    issue(DIV, 32'h0bad_c0de, 32'hffff_fff9, lat);
    alu_op <= NOP;

    n = 0;
    while (expect_q.size() != 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (expect_q.size() != 0) begin
      timeouts++;
      errors++;
      $display("Timeout: %0d hi/lo checks never ran", expect_q.size());
    end
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+sim
logic/muldiv_pkg.sv
logic/div_if.sv
logic/booth_wallace_mul.sv
logic/radix2_divider.sv
logic/muldiv_unit.sv
logic/hilo_accum.sv
logic/muldiv_top.sv
sim/muldiv_tb.sv

// File: Bender.yml
package:
  name: muldiv

sources:
  - logic/muldiv_pkg.sv
  - logic/div_if.sv
  - logic/booth_wallace_mul.sv
  - logic/radix2_divider.sv
  - logic/muldiv_unit.sv
  - logic/hilo_accum.sv
  - logic/muldiv_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/muldiv_tb.sv
